// File: hw/exec_op_pkg.sv
`default_nettype none

package exec_op_pkg;

	localparam int word_w  = 32;
	localparam int dword_w = 2 * word_w;

	typedef logic [word_w-1:0]  word_t;
	typedef logic [dword_w-1:0] dword_t;
	typedef logic [4:0]         reg_addr_t;
	typedef logic [7:0]         aluop_t;
	typedef logic [2:0]         alusel_t;

	// logic ops
	localparam aluop_t op_and   = 8'b0010_0100;
	localparam aluop_t op_or    = 8'b0010_0101;
	localparam aluop_t op_xor   = 8'b0010_0110;
	localparam aluop_t op_nor   = 8'b0010_0111;

	// shifts
	localparam aluop_t op_sll   = 8'b0111_1100;
	localparam aluop_t op_srl   = 8'b0000_0010;
	localparam aluop_t op_sra   = 8'b0000_0011;

	// arithmetic
	localparam aluop_t op_add   = 8'b0010_0000;
	localparam aluop_t op_addu  = 8'b0010_0001;
	localparam aluop_t op_sub   = 8'b0010_0010;
	localparam aluop_t op_subu  = 8'b0010_0011;
	localparam aluop_t op_addi  = 8'b0101_0101;
	localparam aluop_t op_addiu = 8'b0101_0110;
	localparam aluop_t op_slt   = 8'b0010_1010;
	localparam aluop_t op_sltu  = 8'b0010_1011;
	localparam aluop_t op_clz   = 8'b1011_0000;
	localparam aluop_t op_clo   = 8'b1011_0001;

	// traps, register and immediate forms
	localparam aluop_t op_teq   = 8'b0011_0100;
	localparam aluop_t op_teqi  = 8'b0100_1000;
	localparam aluop_t op_tne   = 8'b0011_0110;
	localparam aluop_t op_tnei  = 8'b0100_1001;
	localparam aluop_t op_tge   = 8'b0011_0000;
	localparam aluop_t op_tgei  = 8'b0100_0100;
	localparam aluop_t op_tgeu  = 8'b0011_0001;
	localparam aluop_t op_tgeiu = 8'b0100_0101;
	localparam aluop_t op_tlt   = 8'b0011_0010;
	localparam aluop_t op_tlti  = 8'b0100_0110;
	localparam aluop_t op_tltu  = 8'b0011_0011;
	localparam aluop_t op_tltiu = 8'b0100_0111;

	// multiply and accumulate
	localparam aluop_t op_mul   = 8'b1010_1001;
	localparam aluop_t op_mult  = 8'b0001_1000;
	localparam aluop_t op_multu = 8'b0001_1001;
	localparam aluop_t op_madd  = 8'b1010_0110;
	localparam aluop_t op_maddu = 8'b1010_1000;
	localparam aluop_t op_msub  = 8'b1010_1010;
	localparam aluop_t op_msubu = 8'b1010_1011;

	// moves
	localparam aluop_t op_mfhi  = 8'b0001_0000;
	localparam aluop_t op_mthi  = 8'b0001_0001;
	localparam aluop_t op_mflo  = 8'b0001_0010;
	localparam aluop_t op_mtlo  = 8'b0001_0011;
	localparam aluop_t op_movz  = 8'b0000_1010;
	localparam aluop_t op_movn  = 8'b0000_1011;
	localparam aluop_t op_mfc0  = 8'b0101_1101;
	localparam aluop_t op_mtc0  = 8'b0110_0000;

	// memory
	localparam aluop_t op_lw    = 8'b1110_0011;
	localparam aluop_t op_sw    = 8'b1110_1011;

	// result classes
	localparam alusel_t res_nop   = 3'b000;
	localparam alusel_t res_logic = 3'b001;
	localparam alusel_t res_shift = 3'b010;
	localparam alusel_t res_move  = 3'b011;
	localparam alusel_t res_arith = 3'b100;
	localparam alusel_t res_mul   = 3'b101;
	localparam alusel_t res_jump  = 3'b110;

endpackage

`default_nettype wire

// File: hw/mips_inst_pkg.sv
`default_nettype none

package mips_inst_pkg;

	localparam int opcode_w = 6;
	localparam int reg_w    = 5;
	localparam int imm_w    = 16;
	localparam int shamt_w  = 5;
	localparam int funct_w  = 6;

	typedef struct packed {
		logic [opcode_w-1:0] opcode;
		logic [reg_w-1:0]    rs;
		logic [reg_w-1:0]    rt;
		logic [imm_w-1:0]    imm;
	} i_fmt_t;

	typedef struct packed {
		logic [opcode_w-1:0] opcode;
		logic [reg_w-1:0]    rs;
		logic [reg_w-1:0]    rt;
		logic [reg_w-1:0]    rd;
		logic [shamt_w-1:0]  shamt;
		logic [funct_w-1:0]  funct;
	} r_fmt_t;

	// same 32 bits, two decodings
	typedef union packed {
		i_fmt_t i_view;
		r_fmt_t r_view;
	} inst_t;

	// exception word layout
	localparam int exc_trap_bit = 10;
	localparam int exc_ov_bit   = 11;
	localparam int exc_keep_lsb = 12;

endpackage

`default_nettype wire

// File: hw/alu_bitwise.sv
`timescale 1ns/10ps
`default_nettype none

module alu_bitwise (
	input  wire exec_op_pkg::aluop_t aluop_i,
	input  wire exec_op_pkg::word_t  reg1_i,
	input  wire exec_op_pkg::word_t  reg2_i,
	output exec_op_pkg::word_t       logic_res_o,
	output exec_op_pkg::word_t       shift_res_o
);
	import exec_op_pkg::*;

	logic [4:0] shamt;

	// shift amount comes from the low bits of the first operand
	assign shamt = reg1_i[4:0];

	always_comb begin
		case (aluop_i)
			op_or:   logic_res_o = reg1_i | reg2_i;
			op_and:  logic_res_o = reg1_i & reg2_i;
			op_nor:  logic_res_o = ~(reg1_i | reg2_i);
			op_xor:  logic_res_o = reg1_i ^ reg2_i;
			default: logic_res_o = '0;
		endcase
	end

	always_comb begin
		case (aluop_i)
			op_sll:  shift_res_o = reg2_i << shamt;
			op_srl:  shift_res_o = reg2_i >> shamt;
			// sign fills from the top
			op_sra:  shift_res_o = $signed(reg2_i) >>> shamt;
			default: shift_res_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/alu_arith.sv
`timescale 1ns/10ps
`default_nettype none

module alu_arith (
	input  wire exec_op_pkg::aluop_t aluop_i,
	input  wire exec_op_pkg::word_t  reg1_i,
	input  wire exec_op_pkg::word_t  reg2_i,
	output exec_op_pkg::word_t       arith_res_o,
	output logic                     ov_o,
	output logic                     trap_o
);
	import exec_op_pkg::*;

	logic       is_sub;
	logic       signed_cmp;
	word_t      b_mux;
	word_t      sum;
	logic       lt;
	word_t      lc_in;
	logic [5:0] lead;

	function automatic logic [5:0] lead_zeros(input word_t w);
		logic [5:0] n;
		n = 6'd32;
		// highest set bit is seen last and wins
		for (int i = 0; i < word_w; i++) begin
			if (w[i]) begin
				n = 6'(word_w - 1 - i);
			end
		end
		return n;
	endfunction

	assign signed_cmp = (aluop_i == op_slt) || (aluop_i == op_tlt) || (aluop_i == op_tlti) ||
		(aluop_i == op_tge) || (aluop_i == op_tgei);
	assign is_sub = signed_cmp || (aluop_i == op_sub) || (aluop_i == op_subu);

	// subtract as a + ~b + 1
	assign b_mux = is_sub ? ~reg2_i : reg2_i;
	assign sum   = reg1_i + b_mux + word_t'(is_sub);

	assign ov_o = ((aluop_i == op_add) || (aluop_i == op_addi) || (aluop_i == op_sub)) &&
		(reg1_i[word_w-1] == b_mux[word_w-1]) && (sum[word_w-1] != reg1_i[word_w-1]);

	// signed: differing signs decide directly, else the sign of the difference
	assign lt = signed_cmp ?
		((reg1_i[word_w-1] & ~reg2_i[word_w-1]) |
		(~(reg1_i[word_w-1] ^ reg2_i[word_w-1]) & sum[word_w-1])) :
		(reg1_i < reg2_i);

	// clo is clz of the inverted operand
	assign lc_in = (aluop_i == op_clo) ? ~reg1_i : reg1_i;
	assign lead  = lead_zeros(lc_in);

	always_comb begin
		case (aluop_i)
			op_slt, op_sltu:                    arith_res_o = word_t'(lt);
			op_add, op_addu, op_addi, op_addiu: arith_res_o = sum;
			op_sub, op_subu:                    arith_res_o = sum;
			op_clz, op_clo:                     arith_res_o = word_t'(lead);
			default:                            arith_res_o = '0;
		endcase
	end

	always_comb begin
		case (aluop_i)
			op_teq, op_teqi:                     trap_o = (reg1_i == reg2_i);
			op_tne, op_tnei:                     trap_o = (reg1_i != reg2_i);
			op_tge, op_tgei, op_tgeu, op_tgeiu: trap_o = ~lt;
			op_tlt, op_tlti, op_tltu, op_tltiu: trap_o = lt;
			default:                             trap_o = 1'b0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/mul_acc_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mul_acc_unit (
	input  wire                      clk,
	input  wire                      rst_n_i,
	input  wire exec_op_pkg::aluop_t aluop_i,
	input  wire exec_op_pkg::word_t  reg1_i,
	input  wire exec_op_pkg::word_t  reg2_i,
	input  wire exec_op_pkg::word_t  hi_i,
	input  wire exec_op_pkg::word_t  lo_i,
	output exec_op_pkg::dword_t      product_o,
	output logic                     acc_we_o,
	output exec_op_pkg::dword_t      acc_value_o,
	output logic                     stall_o
);
	import exec_op_pkg::*;

	logic                       signed_op;
	logic                       is_msub;
	logic                       is_acc;
	logic [word_w:0]            a_ext;
	logic [word_w:0]            b_ext;
	logic signed [dword_w+1:0]  prod_wide;
	logic                       phase_q;
	dword_t                     acc_term_q;

	assign signed_op = (aluop_i == op_mul) || (aluop_i == op_mult) ||
		(aluop_i == op_madd) || (aluop_i == op_msub);
	assign is_msub = (aluop_i == op_msub) || (aluop_i == op_msubu);
	assign is_acc  = is_msub || (aluop_i == op_madd) || (aluop_i == op_maddu);

	// one extra bit, sign or zero, covers both signed and unsigned forms
	assign a_ext     = {signed_op & reg1_i[word_w-1], reg1_i};
	assign b_ext     = {signed_op & reg2_i[word_w-1], reg2_i};
	assign prod_wide = $signed(a_ext) * $signed(b_ext);
	assign product_o = prod_wide[dword_w-1:0];

	// phase 0 holds the pipe, phase 1 writes HI:LO
	assign stall_o     = is_acc & ~phase_q;
	assign acc_we_o    = is_acc & phase_q;
	assign acc_value_o = {hi_i, lo_i} + acc_term_q;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			phase_q <= 1'b0;
		end else begin
			// also drops back to zero on any other op
			phase_q <= stall_o;
		end
	end

	always_ff @(posedge clk) begin
		if (stall_o) begin
			acc_term_q <= is_msub ? -product_o : product_o;
		end
	end

endmodule

`default_nettype wire

// File: hw/hilo_reg.sv
`timescale 1ns/10ps
`default_nettype none

module hilo_reg (
	input  wire                      clk,
	input  wire                      rst_n_i,
	input  wire exec_op_pkg::aluop_t aluop_i,
	input  wire exec_op_pkg::word_t  reg1_i,
	input  wire exec_op_pkg::dword_t product_i,
	input  wire                      acc_we_i,
	input  wire exec_op_pkg::dword_t acc_value_i,
	output exec_op_pkg::word_t       hi_o,
	output exec_op_pkg::word_t       lo_o,
	output exec_op_pkg::word_t       move_res_o
);
	import exec_op_pkg::*;

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			hi_o <= '0;
			lo_o <= '0;
		end else if ((aluop_i == op_mult) || (aluop_i == op_multu)) begin
			{hi_o, lo_o} <= product_i;
		end else if (acc_we_i) begin
			{hi_o, lo_o} <= acc_value_i;
		end else if (aluop_i == op_mthi) begin
			hi_o <= reg1_i;
		end else if (aluop_i == op_mtlo) begin
			lo_o <= reg1_i;
		end
	end

	// movz/movn pass reg1, the write decision is made upstream
	always_comb begin
		case (aluop_i)
			op_mfhi:          move_res_o = hi_o;
			op_mflo:          move_res_o = lo_o;
			op_movz, op_movn: move_res_o = reg1_i;
			default:          move_res_o = '0;
		endcase
	end

endmodule

`default_nettype wire

// File: hw/ex_mem_reg.sv
`timescale 1ns/10ps
`default_nettype none

module ex_mem_reg (
	input  wire                         clk,
	input  wire                         rst_n_i,
	input  wire exec_op_pkg::aluop_t    aluop_i,
	input  wire exec_op_pkg::alusel_t   alusel_i,
	input  wire exec_op_pkg::word_t     reg1_i,
	input  wire exec_op_pkg::word_t     reg2_i,
	input  wire exec_op_pkg::reg_addr_t wd_i,
	input  wire                         wreg_i,
	input  wire mips_inst_pkg::inst_t   inst_i,
	input  wire exec_op_pkg::word_t     excepttype_i,
	input  wire exec_op_pkg::word_t     link_address_i,
	input  wire exec_op_pkg::word_t     cp0_rdata_i,
	input  wire exec_op_pkg::word_t     logic_res_i,
	input  wire exec_op_pkg::word_t     shift_res_i,
	input  wire exec_op_pkg::word_t     arith_res_i,
	input  wire exec_op_pkg::word_t     move_res_i,
	input  wire exec_op_pkg::dword_t    product_i,
	input  wire                         ov_i,
	input  wire                         trap_i,
	output exec_op_pkg::reg_addr_t      cp0_raddr_o,
	output exec_op_pkg::reg_addr_t      wd_o,
	output logic                        wreg_o,
	output exec_op_pkg::word_t          wdata_o,
	output exec_op_pkg::word_t          mem_addr_o,
	output exec_op_pkg::aluop_t         aluop_o,
	output exec_op_pkg::word_t          reg2_o,
	output exec_op_pkg::word_t          excepttype_o,
	output logic                        cp0_we_o,
	output exec_op_pkg::reg_addr_t      cp0_waddr_o,
	output exec_op_pkg::word_t          cp0_wdata_o
);
	import exec_op_pkg::*;
	import mips_inst_pkg::*;

	word_t     wdata_d;
	word_t     exc_d;
	word_t     addr_d;
	logic      is_mtc0;
	reg_addr_t cp0_reg;

	assign cp0_reg     = inst_i.r_view.rd;
	assign is_mtc0     = (aluop_i == op_mtc0);
	assign cp0_raddr_o = (aluop_i == op_mfc0) ? cp0_reg : '0;

	// base plus sign-extended offset
	assign addr_d = reg1_i +
		{{(word_w - imm_w){inst_i.i_view.imm[imm_w-1]}}, inst_i.i_view.imm};

	always_comb begin
		case (alusel_i)
			res_logic: wdata_d = logic_res_i;
			res_shift: wdata_d = shift_res_i;
			res_arith: wdata_d = arith_res_i;
			res_move:  wdata_d = (aluop_i == op_mfc0) ? cp0_rdata_i : move_res_i;
			res_mul:   wdata_d = product_i[word_w-1:0];
			res_jump:  wdata_d = link_address_i;
			default:   wdata_d = '0;
		endcase
	end

	// upper bits and 9:8 pass, low byte cleared
	always_comb begin
		exc_d = '0;
		exc_d[word_w-1:exc_keep_lsb] = excepttype_i[word_w-1:exc_keep_lsb];
		exc_d[9:8] = excepttype_i[9:8];
		exc_d[exc_ov_bit] = ov_i;
		exc_d[exc_trap_bit] = trap_i;
	end

	always_ff @(posedge clk or negedge rst_n_i) begin
		if (!rst_n_i) begin
			wd_o         <= '0;
			wreg_o       <= 1'b0;
			wdata_o      <= '0;
			mem_addr_o   <= '0;
			aluop_o      <= '0;
			reg2_o       <= '0;
			excepttype_o <= '0;
			cp0_we_o     <= 1'b0;
			cp0_waddr_o  <= '0;
			cp0_wdata_o  <= '0;
		end else begin
			wd_o         <= wd_i;
			// overflow kills the register write
			wreg_o       <= wreg_i & ~ov_i;
			wdata_o      <= wdata_d;
			mem_addr_o   <= addr_d;
			aluop_o      <= aluop_i;
			reg2_o       <= reg2_i;
			excepttype_o <= exc_d;
			cp0_we_o     <= is_mtc0;
			cp0_waddr_o  <= is_mtc0 ? cp0_reg : '0;
			cp0_wdata_o  <= is_mtc0 ? reg1_i : '0;
		end
	end

endmodule

`default_nettype wire

// File: hw/exec_top.sv
`timescale 1ns/10ps
`default_nettype none

module exec_top (
	input  wire                         clk,
	input  wire                         rst_n_i,
	input  wire exec_op_pkg::aluop_t    aluop_i,
	input  wire exec_op_pkg::alusel_t   alusel_i,
	input  wire exec_op_pkg::word_t     reg1_i,
	input  wire exec_op_pkg::word_t     reg2_i,
	input  wire exec_op_pkg::reg_addr_t wd_i,
	input  wire                         wreg_i,
	input  wire mips_inst_pkg::inst_t   inst_i,
	input  wire exec_op_pkg::word_t     excepttype_i,
	input  wire exec_op_pkg::word_t     link_address_i,
	input  wire exec_op_pkg::word_t     cp0_rdata_i,
	output exec_op_pkg::reg_addr_t      cp0_raddr_o,
	output exec_op_pkg::reg_addr_t      wd_o,
	output logic                        wreg_o,
	output exec_op_pkg::word_t          wdata_o,
	output exec_op_pkg::word_t          mem_addr_o,
	output exec_op_pkg::aluop_t         aluop_o,
	output exec_op_pkg::word_t          reg2_o,
	output exec_op_pkg::word_t          excepttype_o,
	output logic                        cp0_we_o,
	output exec_op_pkg::reg_addr_t      cp0_waddr_o,
	output exec_op_pkg::word_t          cp0_wdata_o,
	output logic                        stall_o
);
	import exec_op_pkg::*;

	word_t  logic_res;
	word_t  shift_res;
	word_t  arith_res;
	logic   ov;
	logic   trap;
	dword_t product;
	logic   acc_we;
	dword_t acc_value;
	word_t  hi;
	word_t  lo;
	word_t  move_res;

	alu_bitwise alu_bitwise_i (
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.logic_res_o (logic_res),
		.shift_res_o (shift_res)
	);

	alu_arith alu_arith_i (
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.arith_res_o (arith_res),
		.ov_o        (ov),
		.trap_o      (trap)
	);

	// accumulate base comes back from the HI/LO register
	mul_acc_unit mul_acc_unit_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.reg2_i      (reg2_i),
		.hi_i        (hi),
		.lo_i        (lo),
		.product_o   (product),
		.acc_we_o    (acc_we),
		.acc_value_o (acc_value),
		.stall_o     (stall_o)
	);

	hilo_reg hilo_reg_i (
		.clk         (clk),
		.rst_n_i     (rst_n_i),
		.aluop_i     (aluop_i),
		.reg1_i      (reg1_i),
		.product_i   (product),
		.acc_we_i    (acc_we),
		.acc_value_i (acc_value),
		.hi_o        (hi),
		.lo_o        (lo),
		.move_res_o  (move_res)
	);

	ex_mem_reg ex_mem_reg_i (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.aluop_i        (aluop_i),
		.alusel_i       (alusel_i),
		.reg1_i         (reg1_i),
		.reg2_i         (reg2_i),
		.wd_i           (wd_i),
		.wreg_i         (wreg_i),
		.inst_i         (inst_i),
		.excepttype_i   (excepttype_i),
		.link_address_i (link_address_i),
		.cp0_rdata_i    (cp0_rdata_i),
		.logic_res_i    (logic_res),
		.shift_res_i    (shift_res),
		.arith_res_i    (arith_res),
		.move_res_i     (move_res),
		.product_i      (product),
		.ov_i           (ov),
		.trap_i         (trap),
		.cp0_raddr_o    (cp0_raddr_o),
		.wd_o           (wd_o),
		.wreg_o         (wreg_o),
		.wdata_o        (wdata_o),
		.mem_addr_o     (mem_addr_o),
		.aluop_o        (aluop_o),
		.reg2_o         (reg2_o),
		.excepttype_o   (excepttype_o),
		.cp0_we_o       (cp0_we_o),
		.cp0_waddr_o    (cp0_waddr_o),
		.cp0_wdata_o    (cp0_wdata_o)
	);

endmodule

`default_nettype wire

// File: test/exec_checker.sv
`timescale 1ns/10ps
`default_nettype none

module exec_checker (
	input wire                     clk,
	input wire                     rst_n_i,
	input wire                     stall_i,
	input wire                     wreg_i,
	input wire                     cp0_we_i,
	input wire exec_op_pkg::word_t excepttype_i
);
	import mips_inst_pkg::*;

	int fail_cnt = 0;

	// accumulate holds the pipe for exactly one cycle
	stall_once: assert property (@(posedge clk) disable iff (!rst_n_i) stall_i |=> !stall_i)
		else begin
			fail_cnt++;
			$error("stall_o high for two cycles in a row");
		end

	// overflow must kill the register write
	ov_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
		excepttype_i[exc_ov_bit] |-> !wreg_i)
		else begin
			fail_cnt++;
			$error("overflow bit set while wreg_o is high");
		end

	reset_quiet: assert property (@(posedge clk) !rst_n_i |-> (!wreg_i && !cp0_we_i))
		else begin
			fail_cnt++;
			$error("register or cp0 write enabled during reset");
		end

endmodule

bind exec_top exec_checker exec_checker_i (
	.clk          (clk),
	.rst_n_i      (rst_n_i),
	.stall_i      (stall_o),
	.wreg_i       (wreg_o),
	.cp0_we_i     (cp0_we_o),
	.excepttype_i (excepttype_o)
);

`default_nettype wire

// File: test/exec_top_tb.sv
`timescale 1ns/10ps
`default_nettype none

module exec_top_tb;
	import exec_op_pkg::*;
	import mips_inst_pkg::*;

	localparam int max_rows = 200;

	logic      clk;
	logic      rst_n_i;
	aluop_t    aluop_i;
	alusel_t   alusel_i;
	word_t     reg1_i;
	word_t     reg2_i;
	reg_addr_t wd_i;
	logic      wreg_i;
	inst_t     inst_i;
	word_t     excepttype_i;
	word_t     link_address_i;
	word_t     cp0_rdata_i;
	reg_addr_t cp0_raddr_o;
	reg_addr_t wd_o;
	logic      wreg_o;
	word_t     wdata_o;
	word_t     mem_addr_o;
	aluop_t    aluop_o;
	word_t     reg2_o;
	word_t     excepttype_o;
	logic      cp0_we_o;
	reg_addr_t cp0_waddr_o;
	word_t     cp0_wdata_o;
	logic      stall_o;

	// stimulus and expected columns
	aluop_t    t_op [max_rows];
	alusel_t   t_sel [max_rows];
	word_t     t_a [max_rows];
	word_t     t_b [max_rows];
	word_t     t_inst [max_rows];
	word_t     t_exc [max_rows];
	word_t     e_wdata [max_rows];
	word_t     e_exc [max_rows];
	word_t     e_addr [max_rows];
	word_t     e_cpdata [max_rows];
	logic      e_wreg [max_rows];
	logic      e_stall [max_rows];
	logic      e_cpwe [max_rows];
	reg_addr_t e_cpaddr [max_rows];
	reg_addr_t e_raddr [max_rows];

	word_t     hi_m;
	word_t     lo_m;
	int        n_rows;
	int        errors;
	int        cur_row;
	int        assert_fails;
	logic      stall_seen;

	exec_top exec_top_i (.*);

	initial clk = 1'b0;
	always #20 clk = ~clk;

	function automatic word_t cp0_pattern(input int i);
		return {16'hc0de, 16'(i)};
	endfunction

	function automatic word_t link_pattern(input int i);
		return 32'h0040_0000 + word_t'(i * 4);
	endfunction

	function automatic word_t count_lead(input word_t w, input logic bitv);
		word_t n;
		int    k;
		n = '0;
		k = 31;
		while (k >= 0 && w[k] == bitv) begin
			n++;
			k--;
		end
		return n;
	endfunction

	task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			errors++;
			$display("FAIL %0t row %0d %s: got %h expected %h", $time, cur_row, name, got, exp);
		end
	endtask

	// reference model fills one table row and tracks HI/LO in hi_m/lo_m
	task automatic add_row(input aluop_t op, input alusel_t sel, input word_t a, input word_t b,
			input word_t inst);
		logic [32:0] s33;
		logic [63:0] ps;
		logic [63:0] pu;
		logic        ov_m;
		logic        trap_m;
		logic        lt_s;
		logic        lt_u;
		word_t       res;
		word_t       exc;
		lt_s = $signed(a) < $signed(b);
		lt_u = a < b;
		ps = {{32{a[31]}}, a} * {{32{b[31]}}, b};
		pu = {32'b0, a} * {32'b0, b};
		ov_m = 1'b0;
		trap_m = 1'b0;
		res = '0;
		exc = $urandom;
		case (op)
			op_or:   res = a | b;
			op_and:  res = a & b;
			op_nor:  res = ~(a | b);
			op_xor:  res = a ^ b;
			op_sll:  res = b << a[4:0];
			op_srl:  res = b >> a[4:0];
			op_sra:  res = (b >> a[4:0]) | (b[31] ? ~(32'hffff_ffff >> a[4:0]) : 32'h0);
			op_add, op_addi, op_addu, op_addiu: begin
				res = a + b;
				s33 = {a[31], a} + {b[31], b};
				ov_m = (op == op_add || op == op_addi) && (s33[32] != s33[31]);
			end
			op_sub, op_subu: begin
				res = a - b;
				s33 = {a[31], a} - {b[31], b};
				ov_m = (op == op_sub) && (s33[32] != s33[31]);
			end
			op_slt:  res = word_t'(lt_s);
			op_sltu: res = word_t'(lt_u);
			op_clz:  res = count_lead(a, 1'b0);
			op_clo:  res = count_lead(a, 1'b1);
			op_teq, op_teqi:   trap_m = (a == b);
			op_tne, op_tnei:   trap_m = (a != b);
			op_tge, op_tgei:   trap_m = !lt_s;
			op_tgeu, op_tgeiu: trap_m = !lt_u;
			op_tlt, op_tlti:   trap_m = lt_s;
			op_tltu, op_tltiu: trap_m = lt_u;
			op_mul:   res = ps[31:0];
			op_mult:  {hi_m, lo_m} = ps;
			op_multu: {hi_m, lo_m} = pu;
			op_madd:  {hi_m, lo_m} = {hi_m, lo_m} + ps;
			op_maddu: {hi_m, lo_m} = {hi_m, lo_m} + pu;
			op_msub:  {hi_m, lo_m} = {hi_m, lo_m} - ps;
			op_msubu: {hi_m, lo_m} = {hi_m, lo_m} - pu;
			op_mfhi:  res = hi_m;
			op_mflo:  res = lo_m;
			op_mthi:  hi_m = a;
			op_mtlo:  lo_m = a;
			op_movz, op_movn: res = a;
			op_mfc0:  res = cp0_pattern(n_rows);
			default:  res = '0;
		endcase
		if (sel == res_jump) begin
			res = link_pattern(n_rows);
		end
		t_op[n_rows] = op;
		t_sel[n_rows] = sel;
		t_a[n_rows] = a;
		t_b[n_rows] = b;
		t_inst[n_rows] = inst;
		t_exc[n_rows] = exc;
		e_wdata[n_rows] = (sel == res_nop) ? '0 : res;
		e_wreg[n_rows] = !ov_m;
		// bits 31:12 and 9:8 survive while 11 and 10 come from the ALU
		e_exc[n_rows] = (exc & 32'hffff_f300) | (word_t'(ov_m) << exc_ov_bit) |
			(word_t'(trap_m) << exc_trap_bit);
		e_addr[n_rows] = a + {{16{inst[15]}}, inst[15:0]};
		e_stall[n_rows] = (op == op_madd || op == op_maddu || op == op_msub || op == op_msubu);
		e_cpwe[n_rows] = (op == op_mtc0);
		e_cpaddr[n_rows] = (op == op_mtc0) ? inst[15:11] : '0;
		e_cpdata[n_rows] = (op == op_mtc0) ? a : '0;
		e_raddr[n_rows] = (op == op_mfc0) ? inst[15:11] : '0;
		n_rows++;
	endtask

	task automatic build_table();
		aluop_t lops [7];
		aluop_t aops [8];
		aluop_t tops [12];
		aluop_t hilo_ops [6];
		word_t  x;
		word_t  y;
		lops = '{op_or, op_and, op_nor, op_xor, op_sll, op_srl, op_sra};
		aops = '{op_add, op_addu, op_addi, op_addiu, op_sub, op_subu, op_slt, op_sltu};
		tops = '{op_teq, op_teqi, op_tne, op_tnei, op_tge, op_tgei, op_tgeu, op_tgeiu,
			op_tlt, op_tlti, op_tltu, op_tltiu};
		hilo_ops = '{op_mult, op_multu, op_madd, op_msub, op_maddu, op_msubu};
		for (int k = 0; k < 7; k++) begin
			repeat (3) begin
				add_row(lops[k], (k < 4) ? res_logic : res_shift, $urandom, $urandom, $urandom);
			end
		end
		add_row(op_sra, res_shift, 32'd4, 32'h8000_0f00, 32'h0);
		add_row(op_sra, res_shift, 32'd31, 32'hffff_0000, 32'h0);
		// signed and unsigned overflow corners
		add_row(op_add, res_arith, 32'h7fff_ffff, 32'd1, 32'h0);
		add_row(op_addu, res_arith, 32'h7fff_ffff, 32'd1, 32'h0);
		add_row(op_addi, res_arith, 32'h8000_0000, 32'hffff_ffff, 32'h0);
		add_row(op_sub, res_arith, 32'h8000_0000, 32'd1, 32'h0);
		add_row(op_subu, res_arith, 32'h8000_0000, 32'd1, 32'h0);
		add_row(op_slt, res_arith, 32'hffff_ffff, 32'd1, 32'h0);
		add_row(op_sltu, res_arith, 32'hffff_ffff, 32'd1, 32'h0);
		for (int k = 0; k < 8; k++) begin
			repeat (3) begin
				add_row(aops[k], res_arith, $urandom, $urandom, $urandom);
			end
		end
		add_row(op_clz, res_arith, 32'h0, 32'h0, 32'h0);
		add_row(op_clz, res_arith, 32'h1, 32'h0, 32'h0);
		add_row(op_clz, res_arith, $urandom >> 7, 32'h0, 32'h0);
		add_row(op_clo, res_arith, 32'hffff_ffff, 32'h0, 32'h0);
		add_row(op_clo, res_arith, 32'hf000_0000, 32'h0, 32'h0);
		add_row(op_clo, res_arith, $urandom, 32'h0, 32'h0);
		for (int k = 0; k < 12; k++) begin
			x = $urandom;
			y = $urandom;
			add_row(tops[k], res_nop, x, x, $urandom);
			add_row(tops[k], res_nop, x, y, $urandom);
			add_row(tops[k], res_nop, y, x, $urandom);
		end
		add_row(op_mul, res_mul, $urandom, $urandom, 32'h0);
		add_row(op_mult, res_nop, 32'hffff_fffe, 32'd3, 32'h0);
		add_row(op_mfhi, res_move, $urandom, 32'h0, 32'h0);
		add_row(op_mflo, res_move, $urandom, 32'h0, 32'h0);
		for (int k = 0; k < 6; k++) begin
			add_row(hilo_ops[k], res_nop, $urandom, $urandom, 32'h0);
			add_row(op_mfhi, res_move, $urandom, 32'h0, 32'h0);
			add_row(op_mflo, res_move, $urandom, 32'h0, 32'h0);
		end
		add_row(op_mthi, res_nop, 32'h1234_5678, 32'h0, 32'h0);
		add_row(op_mfhi, res_move, 32'h0, 32'h0, 32'h0);
		add_row(op_mflo, res_move, 32'h0, 32'h0, 32'h0);
		add_row(op_mtlo, res_nop, 32'h9abc_def0, 32'h0, 32'h0);
		add_row(op_mfhi, res_move, 32'h0, 32'h0, 32'h0);
		add_row(op_mflo, res_move, 32'h0, 32'h0, 32'h0);
		// back-to-back accumulates
		add_row(op_madd, res_nop, $urandom, $urandom, 32'h0);
		add_row(op_msub, res_nop, $urandom, $urandom, 32'h0);
		add_row(op_mfhi, res_move, 32'h0, 32'h0, 32'h0);
		add_row(op_mflo, res_move, 32'h0, 32'h0, 32'h0);
		add_row(op_movz, res_move, $urandom, 32'h0, 32'h0);
		add_row(op_movn, res_move, $urandom, 32'h5, 32'h0);
		add_row(op_lw, res_nop, $urandom, $urandom, {6'h23, 5'd1, 5'd2, 16'hfff0});
		add_row(op_sw, res_nop, $urandom, $urandom, {6'h2b, 5'd1, 5'd2, 16'h0124});
		add_row(op_mtc0, res_nop, $urandom, 32'h0, {6'h10, 5'd4, 5'd3, 5'd12, 11'd0});
		add_row(op_mfc0, res_move, 32'h0, 32'h0, {6'h10, 5'd0, 5'd3, 5'd14, 11'd0});
		add_row(8'h50, res_jump, 32'h0, 32'h0, 32'h0);
	endtask

	task automatic drive_row(input int i);
		aluop_i = t_op[i];
		alusel_i = t_sel[i];
		reg1_i = t_a[i];
		reg2_i = t_b[i];
		wd_i = reg_addr_t'(i);
		wreg_i = 1'b1;
		inst_i = t_inst[i];
		excepttype_i = t_exc[i];
		link_address_i = link_pattern(i);
		cp0_rdata_i = cp0_pattern(i);
	endtask

	task automatic check_outputs(input int i);
		check_val("wd_o", wd_o, reg_addr_t'(i));
		check_val("wreg_o", wreg_o, e_wreg[i]);
		check_val("wdata_o", wdata_o, e_wdata[i]);
		check_val("mem_addr_o", mem_addr_o, e_addr[i]);
		check_val("aluop_o", aluop_o, t_op[i]);
		check_val("reg2_o", reg2_o, t_b[i]);
		check_val("excepttype_o", excepttype_o, e_exc[i]);
		check_val("cp0_we_o", cp0_we_o, e_cpwe[i]);
		check_val("cp0_waddr_o", cp0_waddr_o, e_cpaddr[i]);
		check_val("cp0_wdata_o", cp0_wdata_o, e_cpdata[i]);
	endtask

	initial begin
		void'($urandom(32'hf176));
		errors = 0;
		n_rows = 0;
		cur_row = -1;
		hi_m = '0;
		lo_m = '0;
		rst_n_i = 1'b0;
		aluop_i = '0;
		alusel_i = '0;
		reg1_i = '0;
		reg2_i = '0;
		wd_i = '0;
		wreg_i = 1'b0;
		inst_i = '0;
		excepttype_i = '0;
		link_address_i = '0;
		cp0_rdata_i = '0;
		build_table();
		repeat (10) @(posedge clk);
		#2;
		rst_n_i = 1'b1;
		#1;
		check_val("wreg_o", wreg_o, 1'b0);
		check_val("cp0_we_o", cp0_we_o, 1'b0);
		check_val("stall_o", stall_o, 1'b0);
		check_val("wdata_o", wdata_o, 32'h0);
		@(posedge clk);
		#2;
		for (int i = 0; i < n_rows; i++) begin
			cur_row = i;
			stall_seen = 1'b0;
			drive_row(i);
			#1;
			check_val("cp0_raddr_o", cp0_raddr_o, e_raddr[i]);
			// hold the row until the stage accepts it
			while (stall_o) begin
				stall_seen = 1'b1;
				@(posedge clk);
				#1;
			end
			check_val("stall_o", stall_seen, e_stall[i]);
			@(posedge clk);
			#2;
			check_outputs(i);
		end
		assert_fails = exec_top_i.exec_checker_i.fail_cnt;
		$display("checks failed: %0d, assertions failed: %0d", errors, assert_fails);
		if (errors == 0 && assert_fails == 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

	// four cycles per row plus the reset time
	initial begin
		#1;
		repeat (n_rows * 4 + 14) @(posedge clk);
		$display("timeout: the stimulus loop did not finish in time");
		$display("TEST FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
hw/exec_op_pkg.sv
hw/mips_inst_pkg.sv
hw/alu_bitwise.sv
hw/alu_arith.sv
hw/mul_acc_unit.sv
hw/hilo_reg.sv
hw/ex_mem_reg.sv
hw/exec_top.sv
test/exec_checker.sv
test/exec_top_tb.sv
